//--- source/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// byte address carried by every memory operation.
`define AddrWidth 32

// register-sized data word.
`define DataWidth 32

// reorder tag that follows an operation from dispatch to result.
`define NickWidth 4

// the RAM decodes only this many low address bits, upper bits are ignored.
`define RamAddrWidth 12

// entries in the store/load buffer.
`define SlbDepth 8

`endif

//--- source/lsuPkg.sv
package lsuPkg;

    // opLoad sign-extends, opLoadU zero-extends.
    typedef enum logic [1:0] {
        opLoad,
        opLoadU,
        opStore
    } memOp_e;

    // users map these to a byte count with their own case.
    typedef enum logic [1:0] {
        lenByte,
        lenHalf,
        lenWord
    } accessLen_e;

    // memRead issues byte reads, memReadLast waits for the final byte to return.
    typedef enum logic [1:0] {
        memIdle,
        memRead,
        memReadLast,
        memWrite
    } memState_e;

endpackage

//--- source/storeLoadBuffer.sv
`include "lsu_macros.svh"

module storeLoadBuffer import lsuPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,

    input  logic                   dispatchEn,
    input  memOp_e                 dispatchOp,
    input  logic [`AddrWidth-1:0]  dispatchAddr,
    input  logic [`DataWidth-1:0]  dispatchData,
    input  accessLen_e             dispatchLen,
    input  logic [`NickWidth-1:0]  dispatchNick,
    output logic                   slbFull,

    input  logic                   portReady,
    output logic                   reqEn,
    output memOp_e                 reqOp,
    output logic [`AddrWidth-1:0]  reqAddr,
    output logic [`DataWidth-1:0]  reqData,
    output accessLen_e             reqLen,
    output logic [`NickWidth-1:0]  reqNick,

    input  logic                   doneEn,
    input  logic [`DataWidth-1:0]  doneData,
    input  logic [`NickWidth-1:0]  doneNick,

    output logic                   resultValid,
    output logic [`DataWidth-1:0]  resultData,
    output logic [`NickWidth-1:0]  resultNick
);

    localparam int PtrWidth = $clog2(`SlbDepth);
    localparam int CntWidth = PtrWidth + 1;

    memOp_e                opQ   [`SlbDepth];
    logic [`AddrWidth-1:0] addrQ [`SlbDepth];
    logic [`DataWidth-1:0] dataQ [`SlbDepth];
    accessLen_e            lenQ  [`SlbDepth];
    logic [`NickWidth-1:0] nickQ [`SlbDepth];

    logic [PtrWidth-1:0] head;
    logic [PtrWidth-1:0] tail;
    logic [CntWidth-1:0] count;
    logic                push;
    logic                resultValidReg;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        if (ptr == PtrWidth'(`SlbDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign slbFull = (count == CntWidth'(`SlbDepth));
    assign push    = dispatchEn & rdy & ~slbFull; // a strobe into a full queue is dropped.

    // the head goes out as soon as the port can take it.
    assign reqEn   = portReady & rdy & (count != '0);
    assign reqOp   = opQ[head];
    assign reqAddr = addrQ[head];
    assign reqData = dataQ[head];
    assign reqLen  = lenQ[head];
    assign reqNick = nickQ[head];

    assign resultValid = resultValidReg & rdy; // a held pulse shows once rdy returns.

    always_ff @(posedge clk) begin
        if (rst) begin
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            resultValidReg <= 1'b0;
        end else if (rdy) begin
            if (push) begin
                tail <= nextPtr(tail);
            end
            if (reqEn) begin
                head <= nextPtr(head);
            end
            if (push && !reqEn) begin
                count <= count + 1'b1;
            end else if (reqEn && !push) begin
                count <= count - 1'b1;
            end
            resultValidReg <= doneEn;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            opQ[tail]   <= dispatchOp;
            addrQ[tail] <= dispatchAddr;
            dataQ[tail] <= dispatchData;
            lenQ[tail]  <= dispatchLen;
            nickQ[tail] <= dispatchNick;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && doneEn) begin
            resultData <= doneData;
            resultNick <= doneNick;
        end
    end

    dispatchWhenFull: assert property (@(posedge clk) disable iff (rst)
        dispatchEn |-> !slbFull)
        else $error("dispatch strobe arrived while the buffer was full");

endmodule

//--- source/dataAccessPort.sv
`include "lsu_macros.svh"

module dataAccessPort import lsuPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,

    input  logic                   reqEn,
    input  memOp_e                 reqOp,
    input  logic [`AddrWidth-1:0]  reqAddr,
    input  logic [`DataWidth-1:0]  reqData,
    input  accessLen_e             reqLen,
    input  logic [`NickWidth-1:0]  reqNick,
    output logic                   portReady,

    input  logic                   memBusy,
    input  logic                   memDone,
    input  logic [`DataWidth-1:0]  memRData,
    output logic                   memEn,
    output logic                   memStore,
    output logic [`AddrWidth-1:0]  memAddr,
    output logic [`DataWidth-1:0]  memWData,
    output accessLen_e             memLen,

    output logic                   doneEn,
    output logic [`DataWidth-1:0]  doneData,
    output logic [`NickWidth-1:0]  doneNick
);

    logic                  occupied;
    logic                  issued;    // the controller has taken the request.
    logic                  doneEnReg;
    memOp_e                savedOp;
    logic [`NickWidth-1:0] savedNick;
    logic                  signFill;
    logic [`DataWidth-1:0] loadValue;

    // the buffer sees the port as ready while reset is held.
    assign portReady = rst | (rdy & ~occupied);

    assign memEn    = occupied & ~issued & ~memBusy & rdy;
    assign memStore = (savedOp == opStore);
    assign doneEn   = doneEnReg & rdy;

    always_comb begin
        signFill = (savedOp == opLoad);
        case (memLen)
            lenByte: loadValue = {{(`DataWidth - 8){signFill & memRData[7]}}, memRData[7:0]};
            lenHalf: loadValue = {{(`DataWidth - 16){signFill & memRData[15]}}, memRData[15:0]};
            default: loadValue = memRData;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            issued    <= 1'b0;
            doneEnReg <= 1'b0;
        end else if (rdy) begin
            doneEnReg <= memDone;
            if (memDone) begin
                occupied <= 1'b0; // the slot frees in the same cycle that doneEn rises.
            end
            if (memEn) begin
                issued <= 1'b1;
            end
            if (reqEn) begin
                occupied <= 1'b1;
                issued   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && reqEn) begin
            savedOp   <= reqOp;
            savedNick <= reqNick;
            memAddr   <= reqAddr;
            memWData  <= reqData;
            memLen    <= reqLen;
        end
        if (rdy && memDone) begin
            doneData <= memStore ? '0 : loadValue;
            doneNick <= savedNick;
        end
    end

    reqIntoBusySlot: assert property (@(posedge clk) disable iff (rst)
        reqEn |-> !occupied)
        else $error("request arrived while the port slot was occupied");

    doneWithoutRequest: assert property (@(posedge clk) disable iff (rst)
        memDone |-> occupied)
        else $error("memory done without an outstanding request");

endmodule

//--- source/memCtrl.sv
`include "lsu_macros.svh"

module memCtrl import lsuPkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rdy,

    input  logic                      memEn,
    input  logic                      memStore,
    input  logic [`AddrWidth-1:0]     memAddr,
    input  logic [`DataWidth-1:0]     memWData,
    input  accessLen_e                memLen,
    output logic                      memBusy,
    output logic                      memDone,
    output logic [`DataWidth-1:0]     memRData,

    output logic                      ramEn,
    output logic                      ramWe,
    output logic [`RamAddrWidth-1:0]  ramAddr,
    output logic [7:0]                ramWData,
    input  logic [7:0]                ramRData
);

    memState_e             state;
    logic [1:0]            byteIdx;  // index of the byte now on the RAM bus.
    logic [1:0]            lastIdx;
    logic [1:0]            lenLast;
    logic                  ramEnReg;
    logic                  ramWeReg;
    logic [`DataWidth-1:0] writeBuf;
    logic [`DataWidth-1:0] readBuf;

    always_comb begin
        case (memLen)
            lenByte: lenLast = 2'd0;
            lenHalf: lenLast = 2'd1;
            default: lenLast = 2'd3;
        endcase
    end

    assign memBusy = (state != memIdle);
    assign ramEn   = ramEnReg & rdy; // a frozen cycle must not re-read and clobber ramRData.
    assign ramWe   = ramWeReg;

    assign memDone = rdy & (((state == memWrite) && (byteIdx == lastIdx)) ||
                            (state == memReadLast));

    // the final byte arrives straight from the RAM in the done cycle.
    always_comb begin
        memRData = readBuf;
        memRData[8 * lastIdx +: 8] = ramRData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= memIdle;
            byteIdx  <= '0;
            lastIdx  <= '0;
            ramEnReg <= 1'b0;
            ramWeReg <= 1'b0;
        end else if (rdy) begin
            case (state)
                memIdle: begin
                    if (memEn) begin
                        ramEnReg <= 1'b1;
                        ramWeReg <= memStore;
                        byteIdx  <= '0;
                        lastIdx  <= lenLast;
                        state    <= memStore ? memWrite : memRead;
                    end
                end
                memWrite: begin
                    if (byteIdx == lastIdx) begin
                        ramEnReg <= 1'b0;
                        ramWeReg <= 1'b0;
                        state    <= memIdle;
                    end else begin
                        byteIdx <= byteIdx + 1'b1;
                    end
                end
                memRead: begin
                    if (byteIdx == lastIdx) begin
                        ramEnReg <= 1'b0;
                        state    <= memReadLast;
                    end else begin
                        byteIdx <= byteIdx + 1'b1;
                    end
                end
                default: state <= memIdle;
            endcase
        end
    end

    // address and data step one byte per cycle, lowest byte first.
    always_ff @(posedge clk) begin
        if (rdy) begin
            case (state)
                memIdle: begin
                    if (memEn) begin
                        ramAddr  <= memAddr[`RamAddrWidth-1:0];
                        ramWData <= memWData[7:0];
                        writeBuf <= memWData >> 8;
                        readBuf  <= '0;
                    end
                end
                memWrite: begin
                    ramAddr  <= ramAddr + 1'b1;
                    ramWData <= writeBuf[7:0];
                    writeBuf <= writeBuf >> 8;
                end
                memRead: begin
                    ramAddr <= ramAddr + 1'b1;
                    if (byteIdx != 2'd0) begin
                        readBuf[8 * (int'(byteIdx) - 1) +: 8] <= ramRData;
                    end
                end
                default: ;
            endcase
        end
    end

    enWhileBusy: assert property (@(posedge clk) disable iff (rst)
        memEn |-> !memBusy)
        else $error("new access presented while the controller was busy");

endmodule

//--- source/byteRam.sv
`include "lsu_macros.svh"

module byteRam (
    input  logic                      clk,
    input  logic                      ramEn,
    input  logic                      ramWe,
    input  logic [`RamAddrWidth-1:0]  ramAddr,
    input  logic [7:0]                ramWData,
    output logic [7:0]                ramRData
);

    localparam int Depth = 1 << `RamAddrWidth;

    logic [7:0] mem [Depth];

    // read data lands one cycle after the enable and holds until the next read.
    always_ff @(posedge clk) begin
        if (ramEn) begin
            if (ramWe) begin
                mem[ramAddr] <= ramWData;
            end else begin
                ramRData <= mem[ramAddr];
            end
        end
    end

endmodule

//--- source/lsuTop.sv
`include "lsu_macros.svh"

module lsuTop import lsuPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,

    input  logic                   dispatchEn,
    input  memOp_e                 dispatchOp,
    input  logic [`AddrWidth-1:0]  dispatchAddr,
    input  logic [`DataWidth-1:0]  dispatchData,
    input  accessLen_e             dispatchLen,
    input  logic [`NickWidth-1:0]  dispatchNick,
    output logic                   slbFull,

    output logic                   resultValid,
    output logic [`DataWidth-1:0]  resultData,
    output logic [`NickWidth-1:0]  resultNick
);

    logic                     portReady;
    logic                     reqEn;
    memOp_e                   reqOp;
    logic [`AddrWidth-1:0]    reqAddr;
    logic [`DataWidth-1:0]    reqData;
    accessLen_e               reqLen;
    logic [`NickWidth-1:0]    reqNick;
    logic                     doneEn;
    logic [`DataWidth-1:0]    doneData;
    logic [`NickWidth-1:0]    doneNick;

    logic                     memEn;
    logic                     memStore;
    logic [`AddrWidth-1:0]    memAddr;
    logic [`DataWidth-1:0]    memWData;
    accessLen_e               memLen;
    logic                     memBusy;
    logic                     memDone;
    logic [`DataWidth-1:0]    memRData;

    logic                     ramEn;
    logic                     ramWe;
    logic [`RamAddrWidth-1:0] ramAddr;
    logic [7:0]               ramWData;
    logic [7:0]               ramRData;

    storeLoadBuffer slb (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .dispatchEn   (dispatchEn),
        .dispatchOp   (dispatchOp),
        .dispatchAddr (dispatchAddr),
        .dispatchData (dispatchData),
        .dispatchLen  (dispatchLen),
        .dispatchNick (dispatchNick),
        .slbFull      (slbFull),
        .portReady    (portReady),
        .reqEn        (reqEn),
        .reqOp        (reqOp),
        .reqAddr      (reqAddr),
        .reqData      (reqData),
        .reqLen       (reqLen),
        .reqNick      (reqNick),
        .doneEn       (doneEn),
        .doneData     (doneData),
        .doneNick     (doneNick),
        .resultValid  (resultValid),
        .resultData   (resultData),
        .resultNick   (resultNick)
    );

    dataAccessPort port (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .reqEn     (reqEn),
        .reqOp     (reqOp),
        .reqAddr   (reqAddr),
        .reqData   (reqData),
        .reqLen    (reqLen),
        .reqNick   (reqNick),
        .portReady (portReady),
        .memBusy   (memBusy),
        .memDone   (memDone),
        .memRData  (memRData),
        .memEn     (memEn),
        .memStore  (memStore),
        .memAddr   (memAddr),
        .memWData  (memWData),
        .memLen    (memLen),
        .doneEn    (doneEn),
        .doneData  (doneData),
        .doneNick  (doneNick)
    );

    memCtrl ctrl (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .memEn    (memEn),
        .memStore (memStore),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memLen   (memLen),
        .memBusy  (memBusy),
        .memDone  (memDone),
        .memRData (memRData),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWData (ramWData),
        .ramRData (ramRData)
    );

    byteRam ram (
        .clk      (clk),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWData (ramWData),
        .ramRData (ramRData)
    );

endmodule

//--- tb/lsuTb.sv
`include "lsu_macros.svh"

module lsuTb import lsuPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [`AddrWidth-1:0] WindowBase = 32'h0000_0340;
    localparam int DirectedOps = 30; // 16 fill stores, 8 store/load, 6 extension.
    localparam int RandomOps   = 200;
    localparam int FreezeOps   = 40;
    localparam int TotalOps    = DirectedOps + RandomOps + FreezeOps;

    logic                  clk;
    logic                  rst;
    logic                  rdy;
    logic                  dispatchEn;
    memOp_e                dispatchOp;
    logic [`AddrWidth-1:0] dispatchAddr;
    logic [`DataWidth-1:0] dispatchData;
    accessLen_e            dispatchLen;
    logic [`NickWidth-1:0] dispatchNick;
    logic                  slbFull;
    logic                  resultValid;
    logic [`DataWidth-1:0] resultData;
    logic [`NickWidth-1:0] resultNick;

    logic [7:0]            refMem [64]; // mirrors the 64-byte window at WindowBase.
    logic [31:0]           lfsrState;
    logic [`NickWidth-1:0] nextNick;
    int                    acceptedCount;
    int                    resultCount;

    // expected results in dispatch order.
    logic [`NickWidth-1:0] expNick [$];
    logic [`DataWidth-1:0] expData [$];
    string                 expTest [$];

    lsuTop UUT (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .dispatchEn   (dispatchEn),
        .dispatchOp   (dispatchOp),
        .dispatchAddr (dispatchAddr),
        .dispatchData (dispatchData),
        .dispatchLen  (dispatchLen),
        .dispatchNick (dispatchNick),
        .slbFull      (slbFull),
        .resultValid  (resultValid),
        .resultData   (resultData),
        .resultNick   (resultNick)
    );

    always #4 clk = ~clk;

    task automatic stopWithFail(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // galois form with one output bit taken per step.
    function automatic logic [31:0] randBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
        end
        return value;
    endfunction

    function automatic int byteCount(input accessLen_e len);
        case (len)
            lenByte: return 1;
            lenHalf: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [31:0] fillPattern(input logic [31:0] addr);
        return (addr * 32'h9E37_79B9) ^ {addr[15:0], ~addr[31:16]};
    endfunction

    // little-endian assembly from the model, then sign or zero extension.
    function automatic logic [31:0] expectLoad(input memOp_e op, input int offset,
                                               input accessLen_e len);
        logic [31:0] value;
        value = '0;
        case (len)
            lenByte: begin
                value[7:0] = refMem[offset];
                if (op == opLoad && value[7]) value[31:8] = '1;
            end
            lenHalf: begin
                value[15:0] = {refMem[offset + 1], refMem[offset]};
                if (op == opLoad && value[15]) value[31:16] = '1;
            end
            default: value = {refMem[offset + 3], refMem[offset + 2],
                              refMem[offset + 1], refMem[offset]};
        endcase
        return value;
    endfunction

    // a strobe is followed by one idle cycle so slbFull seen at the negedge is current.
    task automatic sendOp(input memOp_e op, input int offset, input logic [31:0] data,
                          input accessLen_e len, input string testName);
        @(negedge clk);
        while (slbFull) begin
            @(negedge clk);
        end
        @(posedge clk);
        dispatchEn   <= 1'b1;
        dispatchOp   <= op;
        dispatchAddr <= WindowBase + 32'(offset);
        dispatchData <= data;
        dispatchLen  <= len;
        dispatchNick <= nextNick;
        expNick.push_back(nextNick);
        expTest.push_back(testName);
        if (op == opStore) begin
            for (int i = 0; i < byteCount(len); i++) begin
                refMem[offset + i] = data[8 * i +: 8];
            end
            expData.push_back('0);
        end else begin
            expData.push_back(expectLoad(op, offset, len));
        end
        nextNick = nextNick + 1'b1;
        acceptedCount++;
        @(posedge clk);
        dispatchEn <= 1'b0;
    endtask

    task automatic sendRandomOp(input string testName);
        memOp_e      op;
        accessLen_e  len;
        int          offset;
        logic [31:0] data;
        case (randBits(2))
            2'd0:    op = opLoad;
            2'd1:    op = opLoadU;
            default: op = opStore;
        endcase
        case (randBits(2))
            2'd0:    len = lenByte;
            2'd1:    len = lenHalf;
            default: len = lenWord;
        endcase
        offset = int'(randBits(6)) & ~(byteCount(len) - 1); // aligned to its own length.
        data = randBits(32);
        sendOp(op, offset, data, len, testName);
    endtask

    task automatic storeLoadTests();
        sendOp(opStore, 8, 32'hDEAD_BEEF, lenWord, "storeLoad");
        sendOp(opLoad, 8, '0, lenWord, "storeLoad");
        sendOp(opStore, 18, 32'h0000_5A3C, lenHalf, "storeLoad");
        sendOp(opLoad, 18, '0, lenHalf, "storeLoad");
        sendOp(opLoadU, 16, '0, lenWord, "storeLoad");
        sendOp(opStore, 33, 32'hFFFF_FF6E, lenByte, "storeLoad");
        sendOp(opLoadU, 33, '0, lenByte, "storeLoad");
        sendOp(opLoad, 32, '0, lenWord, "storeLoad");
    endtask

    task automatic extensionTests();
        sendOp(opStore, 41, 32'h0000_0080, lenByte, "extension");
        sendOp(opLoad, 41, '0, lenByte, "extension");
        sendOp(opLoadU, 41, '0, lenByte, "extension");
        sendOp(opStore, 46, 32'h0000_FF01, lenHalf, "extension");
        sendOp(opLoad, 46, '0, lenHalf, "extension");
        sendOp(opLoadU, 46, '0, lenHalf, "extension");
    endtask

    resetQuiet: assert property (@(posedge clk) rst |=> (!resultValid && !slbFull))
        else stopWithFail("resultValid or slbFull was high during or right after reset");

    freezeNoResult: assert property (@(posedge clk) disable iff (rst)
        !rdy |-> !resultValid)
        else stopWithFail("a result was broadcast while rdy was low");

    freezeFullHeld: assert property (@(posedge clk) disable iff (rst)
        !$past(rdy) |-> $stable(slbFull))
        else stopWithFail("slbFull changed while rdy was low");

    // each visible result is compared with the oldest outstanding dispatch.
    always @(negedge clk) begin
        if (!rst && resultValid) begin
            assert (expNick.size() != 0)
                else stopWithFail("a result arrived with no operation outstanding");
            assert (resultNick === expNick[0])
                else stopWithFail($sformatf("[FAIL] %s nick expected %h actual %h",
                                            expTest[0], expNick[0], resultNick));
            assert (resultData === expData[0])
                else stopWithFail($sformatf("[FAIL] %s data expected %h actual %h",
                                            expTest[0], expData[0], resultData));
            void'(expNick.pop_front());
            void'(expData.pop_front());
            void'(expTest.pop_front());
            resultCount++;
        end
    end

    initial begin
        repeat (40 * TotalOps) @(posedge clk);
        stopWithFail("watchdog expired before all results came back");
    end

    initial begin
        int holdLen;
        int drainCycles;
        clk           = 1'b0;
        rst           = 1'b1;
        rdy           = 1'b1;
        dispatchEn    = 1'b0;
        dispatchOp    = opLoad;
        dispatchAddr  = '0;
        dispatchData  = '0;
        dispatchLen   = lenByte;
        dispatchNick  = '0;
        lfsrState     = 32'h7964_5ff3;
        nextNick      = '0;
        acceptedCount = 0;
        resultCount   = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // every word of the window gets a known value before any load.
        for (int offset = 0; offset < 64; offset += 4) begin
            sendOp(opStore, offset, fillPattern(WindowBase + 32'(offset)), lenWord, "fill");
        end
        storeLoadTests();
        extensionTests();
        for (int i = 0; i < RandomOps; i++) begin
            sendRandomOp("randomBurst");
        end
        for (int i = 0; i < FreezeOps; i++) begin
            if (randBits(1) == 32'd1) begin
                holdLen = 1 + int'(randBits(4));
                @(posedge clk);
                rdy <= 1'b0;
                repeat (holdLen) @(posedge clk);
                rdy <= 1'b1;
            end
            sendRandomOp("freeze");
        end

        // a full buffer plus the port slot drains within the per-operation budget.
        drainCycles = 0;
        while (expNick.size() != 0 && drainCycles < 40 * (`SlbDepth + 1)) begin
            @(posedge clk);
            drainCycles++;
        end
        repeat (20) @(posedge clk); // a stray late result would still be caught here.
        if (resultCount == acceptedCount) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stopWithFail($sformatf("[FAIL] backPressure results expected %0d actual %0d",
                                   acceptedCount, resultCount));
        end
    end

endmodule

//--- sources.f
+incdir+source
source/lsuPkg.sv
source/storeLoadBuffer.sv
source/dataAccessPort.sv
source/memCtrl.sv
source/byteRam.sv
source/lsuTop.sv
tb/lsuTb.sv

//--- run.sh
#!/bin/sh
# builds the lsuTb simulation with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module lsuTb -o lsuSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/lsuSim)
simStatus=$?
printf '%s\n' "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOutput" | grep -qxF '*** PASSED ***'; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
